// File: adc_unfolding.sv
`timescale 1ns/1ns

module adc_unfolding import dcore_pkg::*; #(
    parameter int SLICE = 0
) (
    input  wire logic            clk_adc_i,
    input  wire logic            rst_n_i,
    input  wire logic [NADC-1:0] din_i,
    input  wire logic            sign_i,
    calib_cfg_if.slice           cfg_if,
    output      sample_t         dout_o
);

    sample_t                   mag;
    sample_t                   unfolded;
    logic signed [NADC+1:0]    diff;
    sample_t                   dout_nxt;
    sample_t                   offset_q;

    logic signed [ACC_W-1:0]   acc_q;
    logic signed [ACC_W-1:0]   acc_nxt;
    logic signed [ACC_W-1:0]   avg_full;
    logic [CNT_W-1:0]          cnt_q;
    logic                      win_end;

    // Sign bit of 1 means positive
    assign mag      = {1'b0, din_i};
    assign unfolded = sign_i ? mag : -mag;

    assign diff = unfolded - offset_q;

    always_comb begin
        if (diff > SAMPLE_MAX) begin
            dout_nxt = sample_t'(SAMPLE_MAX);
        end else if (diff < -SAMPLE_MAX) begin
            dout_nxt = sample_t'(-SAMPLE_MAX);
        end else begin
            dout_nxt = diff[NADC:0];
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            dout_o <= '0;
        end else begin
            dout_o <= dout_nxt;
        end
    end

    // Window closes after 2^navg samples
    assign win_end  = (cnt_q == CNT_W'((1 << cfg_if.navg) - 1));
    assign acc_nxt  = acc_q + unfolded;
    assign avg_full = acc_nxt >>> cfg_if.navg;

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
            cnt_q <= '0;
        end else if (!cfg_if.en_pfd_cal) begin
            acc_q <= '0;
            cnt_q <= '0;
        end else if (win_end) begin
            acc_q <= '0;
            cnt_q <= '0;
        end else begin
            acc_q <= acc_nxt;
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // External value wins over the calibrated one
    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            offset_q <= '0;
        end else if (cfg_if.en_ext_pfd_offset) begin
            offset_q <= cfg_if.ext_pfd_offset[SLICE];
        end else if (cfg_if.en_pfd_cal && win_end) begin
            offset_q <= avg_full[NADC:0];
        end
    end

    assign cfg_if.pfd_offset[SLICE] = offset_q;

endmodule

// File: calib_cfg_if.sv
`timescale 1ns/1ns

interface calib_cfg_if import dcore_pkg::*; ();

    logic                en_pfd_cal;
    logic                en_ext_pfd_offset;
    sample_t             ext_pfd_offset [NTI];
    logic [NAVG_W-1:0]   navg;
    // One entry per slice, driven back by that slice
    sample_t             pfd_offset [NTI];

    modport cfg (
        output en_pfd_cal,
        output en_ext_pfd_offset,
        output ext_pfd_offset,
        output navg,
        input  pfd_offset
    );

    modport slice (
        input  en_pfd_cal,
        input  en_ext_pfd_offset,
        input  ext_pfd_offset,
        input  navg,
        output pfd_offset
    );

endinterface

// File: compile.f
+incdir+.
dcore_pkg.sv
calib_cfg_if.sv
ti_adc_retimer.sv
adc_unfolding.sv
mm_cdr.sv
oneshot_memory.sv
digital_core.sv
tb_digital_core.sv

// File: dcore_pkg.sv
package dcore_pkg;

    // Link dimensions
    localparam int NTI       = 4;
    localparam int NADC      = 8;
    localparam int NPI       = 8;
    localparam int NOUT      = 4;

    // Capture memory
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW    = 6;

    // Control field widths
    localparam int NAVG_W    = 4;
    localparam int SHIFT_W   = 4;

    // Unfolded sample range is symmetric
    localparam int SAMPLE_MAX = 2**NADC - 1;

    // Averaging window of up to 2^(2^NAVG_W - 1) samples
    localparam int CNT_W     = 2**NAVG_W - 1;
    localparam int ACC_W     = NADC + 1 + CNT_W;

    // Capture FSM encodings
    localparam logic [1:0] MEM_IDLE  = 2'd0;
    localparam logic [1:0] MEM_WRITE = 2'd1;
    localparam logic [1:0] MEM_DONE  = 2'd2;

    typedef logic signed [NADC:0] sample_t;

    typedef sample_t adc_word_t [NTI];

    typedef logic [NPI-1:0] pi_code_t;

    typedef logic signed [15:0] pd_t;

    // Slice 0 sits in the low bits
    typedef logic [NTI*(NADC+1)-1:0] mem_word_t;

endpackage

// File: digital_core.sv
`timescale 1ns/1ns

module digital_core import dcore_pkg::*; (
    input  wire logic               clk_adc_i,
    input  wire logic               rst_n_i,
    input  wire logic [NADC-1:0]    adcout_i [NTI],
    input  wire logic [NTI-1:0]     adcout_sign_i,
    input  wire logic               en_pfd_cal_i,
    input  wire logic               en_ext_pfd_offset_i,
    input  wire sample_t            ext_pfd_offset_i [NTI],
    input  wire logic [NAVG_W-1:0]  navg_i,
    output      sample_t            pfd_offset_o [NTI],
    input  wire logic               en_cdr_i,
    input  wire logic [SHIFT_W-1:0] kp_shift_i,
    input  wire logic [SHIFT_W-1:0] ki_shift_i,
    input  wire pi_code_t           pi_ctl_ext_i,
    input  wire pi_code_t           pi_ctl_offset_i [NOUT],
    input  wire logic [3:0]         max_sel_i [NOUT],
    output      pi_code_t           int_pi_ctl_o [NOUT],
    input  wire logic               ext_dump_start_i,
    output      logic               capture_done_o,
    input  wire logic [MEM_AW-1:0]  rd_addr_i,
    input  wire logic               rd_addr_valid_i,
    output      logic               rd_addr_ready_o,
    output      mem_word_t          rd_data_o,
    output      logic               rd_data_valid_o,
    input  wire logic               rd_data_ready_i
);

    logic [NADC-1:0] adcout_retimed [NTI];
    logic [NTI-1:0]  adcout_sign_retimed;
    adc_word_t       adcout_unfolded;

    calib_cfg_if calib_if ();

    // Top-level ports stand in for the configuration registers
    assign calib_if.en_pfd_cal        = en_pfd_cal_i;
    assign calib_if.en_ext_pfd_offset = en_ext_pfd_offset_i;
    assign calib_if.ext_pfd_offset    = ext_pfd_offset_i;
    assign calib_if.navg              = navg_i;
    assign pfd_offset_o               = calib_if.pfd_offset;

    ti_adc_retimer retimer_inst (
        .clk_adc_i     (clk_adc_i),
        .rst_n_i       (rst_n_i),
        .adcout_i      (adcout_i),
        .adcout_sign_i (adcout_sign_i),
        .data_o        (adcout_retimed),
        .sign_o        (adcout_sign_retimed)
    );

    for (genvar k = 0; k < NTI; k++) begin : g_slice
        adc_unfolding #(
            .SLICE (k)
        ) unfold_inst (
            .clk_adc_i (clk_adc_i),
            .rst_n_i   (rst_n_i),
            .din_i     (adcout_retimed[k]),
            .sign_i    (adcout_sign_retimed[k]),
            .cfg_if    (calib_if),
            .dout_o    (adcout_unfolded[k])
        );
    end

    mm_cdr cdr_inst (
        .clk_adc_i       (clk_adc_i),
        .rst_n_i         (rst_n_i),
        .din_i           (adcout_unfolded),
        .en_cdr_i        (en_cdr_i),
        .kp_shift_i      (kp_shift_i),
        .ki_shift_i      (ki_shift_i),
        .pi_ctl_ext_i    (pi_ctl_ext_i),
        .pi_ctl_offset_i (pi_ctl_offset_i),
        .max_sel_i       (max_sel_i),
        .int_pi_ctl_o    (int_pi_ctl_o)
    );

    oneshot_memory mem_inst (
        .clk_adc_i       (clk_adc_i),
        .rst_n_i         (rst_n_i),
        .din_i           (adcout_unfolded),
        .start_i         (ext_dump_start_i),
        .capture_done_o  (capture_done_o),
        .rd_addr_i       (rd_addr_i),
        .rd_addr_valid_i (rd_addr_valid_i),
        .rd_addr_ready_o (rd_addr_ready_o),
        .rd_data_o       (rd_data_o),
        .rd_data_valid_o (rd_data_valid_o),
        .rd_data_ready_i (rd_data_ready_i)
    );

endmodule

// File: mm_cdr.sv
`timescale 1ns/1ns

module mm_cdr import dcore_pkg::*; (
    input  wire logic               clk_adc_i,
    input  wire logic               rst_n_i,
    input  wire adc_word_t          din_i,
    input  wire logic               en_cdr_i,
    input  wire logic [SHIFT_W-1:0] kp_shift_i,
    input  wire logic [SHIFT_W-1:0] ki_shift_i,
    input  wire pi_code_t           pi_ctl_ext_i,
    input  wire pi_code_t           pi_ctl_offset_i [NOUT],
    input  wire logic [3:0]         max_sel_i [NOUT],
    output      pi_code_t           int_pi_ctl_o [NOUT]
);

    sample_t            prev_last_q;
    pd_t                pd_sum;
    pd_t                pd_q;
    pd_t                int_q;
    pd_t                int_nxt;
    pi_code_t           base_nxt;
    pi_code_t           base_q;
    pi_code_t           code_sum [NOUT];
    logic [2*NPI-1:0]   prod [NOUT];

    // Mueller-Muller error, previous word's last sample leads the chain
    always_comb begin
        sample_t seq [NTI+1];
        pd_t     cur;
        pd_t     prv;
        pd_sum = '0;
        seq[0] = prev_last_q;
        for (int i = 0; i < NTI; i++) begin
            seq[i+1] = din_i[i];
        end
        for (int i = 0; i < NTI; i++) begin
            cur = pd_t'(seq[i+1]);
            prv = pd_t'(seq[i]);
            pd_sum = pd_sum + ((prv >= 0) ? cur : -cur) - ((cur >= 0) ? prv : -prv);
        end
    end

    // Stage 1: phase detector
    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            prev_last_q <= '0;
            pd_q        <= '0;
        end else begin
            prev_last_q <= din_i[NTI-1];
            pd_q        <= en_cdr_i ? pd_sum : '0;
        end
    end

    // Stage 2: integrator plus proportional path, wraps modulo 256
    assign int_nxt  = int_q + pd_q;
    assign base_nxt = pi_ctl_ext_i
                    + pi_code_t'(int_nxt >>> ki_shift_i)
                    + pi_code_t'(pd_q >>> kp_shift_i);

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            int_q  <= '0;
            base_q <= '0;
        end else begin
            int_q  <= int_nxt;
            base_q <= base_nxt;
        end
    end

    // Stage 3: per-output offset and scale
    always_comb begin
        for (int j = 0; j < NOUT; j++) begin
            code_sum[j] = base_q + pi_ctl_offset_i[j];
            prod[j]     = code_sum[j] * NPI'({max_sel_i[j], 4'b0000});
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            for (int j = 0; j < NOUT; j++) begin
                int_pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < NOUT; j++) begin
                int_pi_ctl_o[j] <= prod[j][2*NPI-1:NPI];
            end
        end
    end

endmodule

// File: oneshot_memory.sv
`timescale 1ns/1ns

module oneshot_memory import dcore_pkg::*; (
    input  wire logic              clk_adc_i,
    input  wire logic              rst_n_i,
    input  wire adc_word_t         din_i,
    input  wire logic              start_i,
    output      logic              capture_done_o,
    input  wire logic [MEM_AW-1:0] rd_addr_i,
    input  wire logic              rd_addr_valid_i,
    output      logic              rd_addr_ready_o,
    output      mem_word_t         rd_data_o,
    output      logic              rd_data_valid_o,
    input  wire logic              rd_data_ready_i
);

    mem_word_t          mem [MEM_DEPTH];
    mem_word_t          din_packed;
    logic [1:0]         state_q;
    logic [MEM_AW-1:0]  wr_cnt_q;
    logic               wr_en;
    logic               rd_accept;

    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            din_packed[k*(NADC+1) +: NADC+1] = din_i[k];
        end
    end

    assign wr_en = (state_q == MEM_WRITE);

    // Capture FSM, one burst per reset
    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            state_q  <= MEM_IDLE;
            wr_cnt_q <= '0;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (start_i) begin
                        state_q  <= MEM_WRITE;
                        wr_cnt_q <= '0;
                    end
                end
                MEM_WRITE: begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                    if (wr_cnt_q == MEM_AW'(MEM_DEPTH - 1)) begin
                        state_q <= MEM_DONE;
                    end
                end
                default: begin
                    state_q <= MEM_DONE;
                end
            endcase
        end
    end

    assign capture_done_o = (state_q == MEM_DONE);

    // Reads open only after the burst, one word in flight
    assign rd_addr_ready_o = capture_done_o && !rd_data_valid_o;
    assign rd_accept       = rd_addr_valid_i && rd_addr_ready_o;

    always_ff @(posedge clk_adc_i) begin
        if (wr_en) begin
            mem[wr_cnt_q] <= din_packed;
        end
        if (rd_accept) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            rd_data_valid_o <= 1'b0;
        end else if (rd_accept) begin
            rd_data_valid_o <= 1'b1;
        end else if (rd_data_ready_i) begin
            rd_data_valid_o <= 1'b0;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_digital_core -o tb_sim \
    || { echo "Verilator build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation ended with an error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// File: tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Sign 1 keeps the magnitude, sign 0 negates it
function automatic int unfold_ref(input int mag, input bit sgn);
    return sgn ? mag : -mag;
endfunction

function automatic sample_t sat_ref(input int v);
    if (v > SAMPLE_MAX) begin
        return sample_t'(SAMPLE_MAX);
    end else if (v < -SAMPLE_MAX) begin
        return sample_t'(-SAMPLE_MAX);
    end
    return sample_t'(v);
endfunction

// Mueller-Muller error of one word, chained from the previous last sample
function automatic int pd_ref(input int prev, input adc_word_t w);
    int acc;
    int p;
    int c;
    acc = 0;
    p   = prev;
    for (int i = 0; i < NTI; i++) begin
        c   = int'(w[i]);
        acc = acc + ((p >= 0) ? c : -c) - ((c >= 0) ? p : -p);
        p   = c;
    end
    return acc;
endfunction

function automatic pi_code_t map_ref(input int base, input int off, input int sel);
    int code;
    code = (base + off) & 255;
    return pi_code_t'((code * sel * 16) >> 8);
endfunction

function automatic mem_word_t pack_ref(input adc_word_t w);
    mem_word_t m;
    for (int k = 0; k < NTI; k++) begin
        m[k*(NADC+1) +: NADC+1] = w[k];
    end
    return m;
endfunction

task automatic check_mem_word(input string name, input mem_word_t exp, input mem_word_t act);
    if (exp !== act) begin
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_pi_code(input string name, input pi_code_t exp, input pi_code_t act);
    if (exp !== act) begin
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_pd(input string name, input pd_t exp, input pd_t act);
    if (exp !== act) begin
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
        errors++;
    end
endtask

`endif

// File: tb_digital_core.sv
`timescale 1ns/1ns

module tb_digital_core import dcore_pkg::*; ();

    localparam int RD_TIMEOUT  = 50;
    localparam int CAL_TIMEOUT = 100;
    localparam int CAP_TIMEOUT = 200;

    logic               clk_adc_i;
    logic               rst_n_i;
    logic [NADC-1:0]    adcout_i [NTI];
    logic [NTI-1:0]     adcout_sign_i;
    logic               en_pfd_cal_i;
    logic               en_ext_pfd_offset_i;
    sample_t            ext_pfd_offset_i [NTI];
    logic [NAVG_W-1:0]  navg_i;
    sample_t            pfd_offset_o [NTI];
    logic               en_cdr_i;
    logic [SHIFT_W-1:0] kp_shift_i;
    logic [SHIFT_W-1:0] ki_shift_i;
    pi_code_t           pi_ctl_ext_i;
    pi_code_t           pi_ctl_offset_i [NOUT];
    logic [3:0]         max_sel_i [NOUT];
    pi_code_t           int_pi_ctl_o [NOUT];
    logic               ext_dump_start_i;
    logic               capture_done_o;
    logic [MEM_AW-1:0]  rd_addr_i;
    logic               rd_addr_valid_i;
    logic               rd_addr_ready_o;
    mem_word_t          rd_data_o;
    logic               rd_data_valid_o;
    logic               rd_data_ready_i;

    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    mem_word_t          exp_q [$];
    mem_word_t          captured [MEM_DEPTH];
    mem_word_t          exp_mem [MEM_DEPTH];

    `include "tb_ref.svh"

    digital_core digital_core_inst (.*);

    always #20 clk_adc_i = ~clk_adc_i;

    task automatic apply_reset();
        @(negedge clk_adc_i);
        rst_n_i = 1'b0;
        repeat (4) @(negedge clk_adc_i);
        rst_n_i = 1'b1;
    endtask

    // Drives a random or zero word and returns its unfolded values
    task automatic drive_word(input bit rnd, output adc_word_t unf);
        @(negedge clk_adc_i);
        for (int k = 0; k < NTI; k++) begin
            adcout_i[k]      = rnd ? NADC'($urandom) : '0;
            adcout_sign_i[k] = rnd ? 1'($urandom % 2) : 1'b1;
            unf[k]           = sample_t'(unfold_ref(int'(adcout_i[k]), adcout_sign_i[k]));
        end
    endtask

    task automatic log_expected(input adc_word_t unf);
        adc_word_t e;
        for (int k = 0; k < NTI; k++) begin
            e[k] = sat_ref(int'(unf[k])
                   - (en_ext_pfd_offset_i ? int'(ext_pfd_offset_i[k]) : 0));
        end
        exp_q.push_back(pack_ref(e));
    endtask

    task automatic send_address(input int addr, output bit ok);
        int n;
        @(negedge clk_adc_i);
        rd_addr_i       = MEM_AW'(addr);
        rd_addr_valid_i = 1'b1;
        n = 0;
        while (!rd_addr_ready_o && n < RD_TIMEOUT) begin
            @(negedge clk_adc_i);
            n++;
        end
        ok = rd_addr_ready_o;
        // Accepted on the rising edge just passed
        @(negedge clk_adc_i);
        rd_addr_valid_i = 1'b0;
        if (!ok) begin
            $display("Read address %0d was never accepted", addr);
            errors++;
        end
    endtask

    task automatic read_word(input int addr, output mem_word_t data);
        int n;
        bit ok;
        bit done;
        send_address(addr, ok);
        n    = 0;
        done = 1'b0;
        data = '0;
        while (ok && !done && n < RD_TIMEOUT) begin
            rd_data_ready_i = ($urandom % 3) != 0;
            if (rd_data_valid_o && rd_data_ready_i) begin
                data = rd_data_o;
                done = 1'b1;
            end
            @(negedge clk_adc_i);
            n++;
        end
        rd_data_ready_i = 1'b0;
        if (ok && !done) begin
            $display("Read data for address %0d never transferred", addr);
            errors++;
        end
    endtask

    task automatic capture_and_check();
        adc_word_t unf;
        int        n;
        int        first;
        exp_q.delete();
        repeat (8) begin
            drive_word(1'b1, unf);
            log_expected(unf);
        end
        if (capture_done_o !== 1'b0) begin
            $display("[FAIL] t=%0t capture_done_o expected 0 got %b", $time, capture_done_o);
            errors++;
        end
        ext_dump_start_i = 1'b1;
        drive_word(1'b1, unf);
        log_expected(unf);
        ext_dump_start_i = 1'b0;
        n = 0;
        while (!capture_done_o && n < CAP_TIMEOUT) begin
            drive_word(1'b1, unf);
            log_expected(unf);
            n++;
        end
        if (!capture_done_o) begin
            $display("capture_done_o did not rise within %0d cycles", CAP_TIMEOUT);
            errors++;
            return;
        end
        if (n != MEM_DEPTH) begin
            $display("[FAIL] t=%0t capture_done_o rise expected after %0d words got %0d",
                     $time, MEM_DEPTH, n);
            errors++;
        end
        for (int a = 0; a < MEM_DEPTH; a++) begin
            read_word(a, captured[a]);
        end
        // First captured word is found by content
        first = -1;
        for (int i = 0; i + MEM_DEPTH <= exp_q.size(); i++) begin
            if (first < 0 && exp_q[i] == captured[0]) begin
                first = i;
            end
        end
        if (first < 0) begin
            $display("First captured word %h not found in the stimulus log", captured[0]);
            errors++;
        end else begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                exp_mem[a] = exp_q[first+a];
                check_mem_word($sformatf("rd_data_o[%0d]", a), exp_mem[a], captured[a]);
            end
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    initial begin
        int        e0;
        int        n;
        int        addr;
        int        pd_sum;
        int        prev;
        bit        ok;
        bit        done;
        adc_word_t unf;
        sample_t   cal_val [NTI];
        mem_word_t held;

        void'($urandom(32'h1411_7101));
        clk_adc_i           = 1'b0;
        rst_n_i             = 1'b0;
        adcout_sign_i       = '0;
        en_pfd_cal_i        = 1'b0;
        en_ext_pfd_offset_i = 1'b0;
        navg_i              = '0;
        en_cdr_i            = 1'b0;
        kp_shift_i          = '0;
        ki_shift_i          = '0;
        pi_ctl_ext_i        = '0;
        ext_dump_start_i    = 1'b0;
        rd_addr_i           = '0;
        rd_addr_valid_i     = 1'b0;
        rd_data_ready_i     = 1'b0;
        for (int k = 0; k < NTI; k++) begin
            adcout_i[k]         = '0;
            ext_pfd_offset_i[k] = '0;
        end
        for (int j = 0; j < NOUT; j++) begin
            pi_ctl_offset_i[j] = '0;
            max_sel_i[j]       = '0;
        end
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        apply_reset();
        e0 = errors;
        capture_and_check();
        finish_test("unfolding and capture", e0);

        // A new burst needs a reset since capture is one-shot
        e0 = errors;
        for (int k = 0; k < NTI; k++) begin
            ext_pfd_offset_i[k] = sample_t'(int'($urandom % 511) - 255);
        end
        en_ext_pfd_offset_i = 1'b1;
        apply_reset();
        capture_and_check();
        finish_test("external offset", e0);

        e0 = errors;
        for (int r = 0; r < 4; r++) begin
            addr = $urandom % MEM_DEPTH;
            rd_data_ready_i = 1'b0;
            send_address(addr, ok);
            n = 0;
            while (!rd_data_valid_o && n < RD_TIMEOUT) begin
                @(negedge clk_adc_i);
                n++;
            end
            if (!rd_data_valid_o) begin
                $display("Read data at address %0d never became valid", addr);
                errors++;
            end
            held = rd_data_o;
            check_mem_word("rd_data_o", exp_mem[addr], held);
            // Other addresses are offered while the word is pending
            repeat (5) begin
                rd_addr_i       = MEM_AW'(addr + 1 + $urandom % (MEM_DEPTH - 1));
                rd_addr_valid_i = 1'b1;
                @(negedge clk_adc_i);
                check_mem_word("rd_data_o", held, rd_data_o);
                if (rd_addr_ready_o !== 1'b0) begin
                    $display("[FAIL] t=%0t rd_addr_ready_o expected 0 got %b",
                             $time, rd_addr_ready_o);
                    errors++;
                end
            end
            rd_addr_valid_i = 1'b0;
            rd_data_ready_i = 1'b1;
            @(negedge clk_adc_i);
            rd_data_ready_i = 1'b0;
            if (rd_data_valid_o !== 1'b0 || rd_addr_ready_o !== 1'b1) begin
                $display("Read at address %0d did not complete once ready rose", addr);
                errors++;
            end
        end
        finish_test("read back-pressure", e0);

        e0 = errors;
        en_ext_pfd_offset_i = 1'b0;
        navg_i = 3;
        @(negedge clk_adc_i);
        for (int k = 0; k < NTI; k++) begin
            adcout_i[k]      = NADC'($urandom);
            adcout_sign_i[k] = 1'($urandom % 2);
            cal_val[k]       = sample_t'(unfold_ref(int'(adcout_i[k]), adcout_sign_i[k]));
        end
        en_pfd_cal_i = 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done && n < CAL_TIMEOUT) begin
            @(negedge clk_adc_i);
            done = 1'b1;
            for (int k = 0; k < NTI; k++) begin
                if (pfd_offset_o[k] !== cal_val[k]) begin
                    done = 1'b0;
                end
            end
            n++;
        end
        if (!done) begin
            $display("Calibration did not settle within %0d cycles", CAL_TIMEOUT);
        end
        for (int k = 0; k < NTI; k++) begin
            check_sample($sformatf("pfd_offset_o[%0d]", k), cal_val[k], pfd_offset_o[k]);
        end
        en_pfd_cal_i = 1'b0;
        finish_test("calibration", e0);

        // Clears the offsets and the integrator
        apply_reset();
        e0 = errors;
        for (int it = 0; it < 20; it++) begin
            drive_word(1'b1, unf);
            pi_ctl_ext_i = pi_code_t'($urandom);
            for (int j = 0; j < NOUT; j++) begin
                pi_ctl_offset_i[j] = pi_code_t'($urandom);
                max_sel_i[j]       = 4'($urandom);
            end
            repeat (3) @(negedge clk_adc_i);
            for (int j = 0; j < NOUT; j++) begin
                check_pi_code($sformatf("int_pi_ctl_o[%0d]", j),
                              map_ref(pi_ctl_ext_i, pi_ctl_offset_i[j], max_sel_i[j]),
                              int_pi_ctl_o[j]);
            end
        end
        finish_test("PI mapping with CDR frozen", e0);

        e0 = errors;
        kp_shift_i = SHIFT_W'($urandom % 8);
        ki_shift_i = SHIFT_W'($urandom % 8);
        // Zero words first so the chain starts from a zero sample
        repeat (6) drive_word(1'b0, unf);
        en_cdr_i = 1'b1;
        pd_sum = 0;
        prev   = 0;
        for (int w = 0; w < 24; w++) begin
            drive_word(1'b1, unf);
            pd_sum = pd_sum + pd_ref(prev, unf);
            prev   = int'(unf[NTI-1]);
        end
        repeat (8) begin
            drive_word(1'b0, unf);
            pd_sum = pd_sum + pd_ref(prev, unf);
            prev   = 0;
        end
        repeat (2) @(negedge clk_adc_i);
        check_pd("cdr_inst.int_q", pd_t'(pd_sum), digital_core_inst.cdr_inst.int_q);
        for (int j = 0; j < NOUT; j++) begin
            check_pi_code($sformatf("int_pi_ctl_o[%0d]", j),
                          map_ref(int'(pi_ctl_ext_i) + int'(pd_t'(pd_sum) >>> ki_shift_i),
                                  pi_ctl_offset_i[j], max_sel_i[j]),
                          int_pi_ctl_o[j]);
        end
        en_cdr_i = 1'b0;
        finish_test("loop integration", e0);

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: ti_adc_retimer.sv
`timescale 1ns/1ns

module ti_adc_retimer import dcore_pkg::*; (
    input  wire logic            clk_adc_i,
    input  wire logic            rst_n_i,
    input  wire logic [NADC-1:0] adcout_i [NTI],
    input  wire logic [NTI-1:0]  adcout_sign_i,
    output      logic [NADC-1:0] data_o [NTI],
    output      logic [NTI-1:0]  sign_o
);

    // Early stage holds the first half, late stage the second half
    logic [NADC-1:0] early_data_q [NTI/2];
    logic [NADC-1:0] late_data_q  [NTI-NTI/2];
    logic [NTI/2-1:0]     early_sign_q;
    logic [NTI-NTI/2-1:0] late_sign_q;

    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NTI/2; i++) begin
                early_data_q[i] <= '0;
            end
            for (int i = 0; i < NTI - NTI/2; i++) begin
                late_data_q[i] <= '0;
            end
            early_sign_q <= '0;
            late_sign_q  <= '0;
        end else begin
            for (int i = 0; i < NTI/2; i++) begin
                early_data_q[i] <= adcout_i[i];
            end
            for (int i = 0; i < NTI - NTI/2; i++) begin
                late_data_q[i] <= adcout_i[i+NTI/2];
            end
            early_sign_q <= adcout_sign_i[NTI/2-1:0];
            late_sign_q  <= adcout_sign_i[NTI-1:NTI/2];
        end
    end

    // Both halves leave together
    always_ff @(posedge clk_adc_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NTI; i++) begin
                data_o[i] <= '0;
            end
            sign_o <= '0;
        end else begin
            for (int i = 0; i < NTI/2; i++) begin
                data_o[i] <= early_data_q[i];
            end
            for (int i = 0; i < NTI - NTI/2; i++) begin
                data_o[i+NTI/2] <= late_data_q[i];
            end
            sign_o <= {late_sign_q, early_sign_q};
        end
    end

endmodule
